/* hw/grid_updater.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_updater (
    input wire clk,
    input wire reset,
    instr_if.sink instr,
    input wire [light_grid_pkg::ROW_INDEX_WIDTH-1:0] scan_row,
    output logic [light_grid_pkg::GRID_SIZE-1:0] scan_bits,
    output logic busy
);

    import light_grid_pkg::*;

    logic [GRID_SIZE-1:0] grid [GRID_SIZE];
    logic [OP_WIDTH-1:0] op_q;
    logic [ROW_INDEX_WIDTH-1:0] row_q;
    logic [ROW_INDEX_WIDTH-1:0] end_row_q;
    logic [ROW_INDEX_WIDTH-1:0] start_col_q;
    logic [ROW_INDEX_WIDTH-1:0] end_col_q;
    logic [GRID_SIZE-1:0] col_mask;
    logic [GRID_SIZE-1:0] row_next;

    always_ff @(posedge clk) begin
        if (instr.valid) begin
            op_q <= instr.op;
            end_row_q <= instr.end_row[ROW_INDEX_WIDTH-1:0];
            start_col_q <= instr.start_col[ROW_INDEX_WIDTH-1:0];
            end_col_q <= instr.end_col[ROW_INDEX_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (instr.valid) begin
            row_q <= instr.start_row[ROW_INDEX_WIDTH-1:0];
        end else if (busy) begin
            row_q <= row_q + 1'b1;
        end
    end

    always_comb begin
        for (int c = 0; c < GRID_SIZE; c++) begin
            col_mask[c] = (ROW_INDEX_WIDTH'(c) >= start_col_q) &&
                          (ROW_INDEX_WIDTH'(c) <= end_col_q);
        end
    end

    always_comb begin
        case (op_q)
            OP_ON: row_next = grid[row_q] | col_mask;
            OP_OFF: row_next = grid[row_q] & ~col_mask;
            OP_TOGGLE: row_next = grid[row_q] ^ col_mask;
            default: row_next = grid[row_q];
        endcase
    end

    // One row per cycle until busy drops with the write of end_row.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            for (int r = 0; r < GRID_SIZE; r++) begin
                grid[r] <= '0;
            end
        end else if (instr.valid) begin
            busy <= 1'b1;
        end else if (busy) begin
            grid[row_q] <= row_next;
            busy <= (row_q != end_row_q);
        end
    end

    assign scan_bits = grid[scan_row];

    a_coords_in_grid: assert property (@(posedge clk) disable iff (reset)
        instr.valid |-> (instr.start_row < POS_WIDTH'(GRID_SIZE)) &&
                        (instr.start_col < POS_WIDTH'(GRID_SIZE)) &&
                        (instr.end_row < POS_WIDTH'(GRID_SIZE)) &&
                        (instr.end_col < POS_WIDTH'(GRID_SIZE)));

    a_coords_ordered: assert property (@(posedge clk) disable iff (reset)
        instr.valid |-> (instr.start_row <= instr.end_row) &&
                        (instr.start_col <= instr.end_col));

    // Lines are long enough that the decoder never outruns a walk.
    a_no_strobe_while_busy: assert property (@(posedge clk) disable iff (reset)
        instr.valid |-> !busy);

endmodule

`default_nettype wire

/* hw/instr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface instr_if;

    import light_grid_pkg::*;

    // Valid is a single-cycle strobe and the fields only count while it is high.
    logic valid;
    logic [OP_WIDTH-1:0] op;
    logic [POS_WIDTH-1:0] start_row;
    logic [POS_WIDTH-1:0] start_col;
    logic [POS_WIDTH-1:0] end_row;
    logic [POS_WIDTH-1:0] end_col;

    modport source (
        output valid, op, start_row, start_col, end_row, end_col
    );

    modport sink (
        input valid, op, start_row, start_col, end_row, end_col
    );

endinterface

`default_nettype wire

/* hw/light_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module light_counter (
    input wire clk,
    input wire reset,
    input wire end_of_file,
    input wire busy,
    output logic [light_grid_pkg::ROW_INDEX_WIDTH-1:0] scan_row,
    input wire [light_grid_pkg::GRID_SIZE-1:0] scan_bits,
    output logic count_valid,
    output logic [light_grid_pkg::COUNT_WIDTH-1:0] light_count
);

    import light_grid_pkg::*;

    logic pending;
    logic scanning;
    logic start_scan;
    logic [COUNT_WIDTH-1:0] row_ones;

    assign start_scan = pending && !busy;

    always_comb begin
        row_ones = '0;
        for (int c = 0; c < GRID_SIZE; c++) begin
            row_ones = row_ones + COUNT_WIDTH'(scan_bits[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            scanning <= 1'b0;
            count_valid <= 1'b0;
            scan_row <= '0;
        end else begin
            count_valid <= 1'b0;
            if (end_of_file) begin
                pending <= 1'b1;
            end
            if (start_scan) begin
                pending <= 1'b0;
                scanning <= 1'b1;
                scan_row <= '0;
            end else if (scanning) begin
                scan_row <= scan_row + 1'b1;
                if (scan_row == ROW_INDEX_WIDTH'(GRID_SIZE - 1)) begin
                    scanning <= 1'b0;
                    count_valid <= 1'b1;
                end
            end
        end
    end

    // Running total whose final value shows up with count_valid.
    always_ff @(posedge clk) begin
        if (start_scan) begin
            light_count <= '0;
        end else if (scanning) begin
            light_count <= light_count + row_ones;
        end
    end

    a_single_eof: assert property (@(posedge clk) disable iff (reset)
        end_of_file |-> !(pending || scanning));

    // No instruction follows end of file, so the grid is stable during a scan.
    a_grid_stable_in_scan: assert property (@(posedge clk) disable iff (reset)
        scanning |-> !busy);

endmodule

`default_nettype wire

/* hw/light_grid_pkg.sv */
`default_nettype none

package light_grid_pkg;

    // Inbound byte stream.
    localparam int CHAR_WIDTH = 8;

    // ASCII codes the decoder reacts to.
    localparam logic [CHAR_WIDTH-1:0] NULL_CHAR = 8'h00;
    localparam logic [CHAR_WIDTH-1:0] LF_CHAR = 8'h0A;
    localparam logic [CHAR_WIDTH-1:0] SPACE_CHAR = 8'h20;
    localparam logic [CHAR_WIDTH-1:0] COMMA_CHAR = 8'h2C;
    localparam logic [CHAR_WIDTH-1:0] ZERO_CHAR = 8'h30;
    localparam logic [CHAR_WIDTH-1:0] NINE_CHAR = 8'h39;
    localparam logic [CHAR_WIDTH-1:0] F_CHAR = 8'h66;
    localparam logic [CHAR_WIDTH-1:0] O_CHAR = 8'h6F;
    localparam logic [CHAR_WIDTH-1:0] N_CHAR = 8'h6E;
    localparam logic [CHAR_WIDTH-1:0] T_CHAR = 8'h74;

    // Wide enough for a full puzzle coordinate before range checks.
    localparam int POS_WIDTH = 12;

    // Operation codes.
    localparam int OP_WIDTH = 2;
    localparam logic [OP_WIDTH-1:0] OP_OFF = 2'd0;
    localparam logic [OP_WIDTH-1:0] OP_TOGGLE = 2'd1;
    localparam logic [OP_WIDTH-1:0] OP_ON = 2'd3;

    // Grid geometry and result width (0 to 256).
    localparam int GRID_SIZE = 16;
    localparam int ROW_INDEX_WIDTH = 4;
    localparam int COUNT_WIDTH = 9;

endpackage

`default_nettype wire

/* hw/light_grid_top.sv */
`timescale 1ns/1ps
`default_nettype none

module light_grid_top (
    input wire clk,
    input wire reset,
    input wire inbound_valid,
    input wire [light_grid_pkg::CHAR_WIDTH-1:0] inbound_data,
    output logic count_valid,
    output logic [light_grid_pkg::COUNT_WIDTH-1:0] light_count
);

    import light_grid_pkg::*;

    logic end_of_file;
    logic busy;
    logic [ROW_INDEX_WIDTH-1:0] scan_row;
    logic [GRID_SIZE-1:0] scan_bits;

    instr_if instr ();

    line_decoder u_line_decoder (
        .clk(clk),
        .reset(reset),
        .inbound_valid(inbound_valid),
        .inbound_data(inbound_data),
        .instr(instr.source),
        .end_of_file(end_of_file)
    );

    grid_updater u_grid_updater (
        .clk(clk),
        .reset(reset),
        .instr(instr.sink),
        .scan_row(scan_row),
        .scan_bits(scan_bits),
        .busy(busy)
    );

    light_counter u_light_counter (
        .clk(clk),
        .reset(reset),
        .end_of_file(end_of_file),
        .busy(busy),
        .scan_row(scan_row),
        .scan_bits(scan_bits),
        .count_valid(count_valid),
        .light_count(light_count)
    );

endmodule

`default_nettype wire

/* hw/line_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module line_decoder (
    input wire clk,
    input wire reset,
    input wire inbound_valid,
    input wire [light_grid_pkg::CHAR_WIDTH-1:0] inbound_data,
    instr_if.source instr,
    output logic end_of_file
);

    import light_grid_pkg::*;

    logic [CHAR_WIDTH-1:0] prev_char;
    logic [POS_WIDTH-1:0] position;
    logic [POS_WIDTH-1:0] digit_value;
    logic [1:0] field;
    logic cur_digit;
    logic prev_digit;
    logic comma_seen;
    logic space_seen;
    logic lf_seen;
    logic null_seen;

    function automatic logic is_digit(input logic [CHAR_WIDTH-1:0] c);
        return (c >= ZERO_CHAR) && (c <= NINE_CHAR);
    endfunction

    assign cur_digit = is_digit(inbound_data);
    assign prev_digit = is_digit(prev_char);
    assign digit_value = POS_WIDTH'(inbound_data - ZERO_CHAR);

    assign comma_seen = inbound_valid && (inbound_data == COMMA_CHAR);
    assign space_seen = inbound_valid && (inbound_data == SPACE_CHAR);
    assign lf_seen = inbound_valid && (inbound_data == LF_CHAR);
    assign null_seen = inbound_valid && (inbound_data == NULL_CHAR);

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_char <= NULL_CHAR;
        end else if (inbound_valid) begin
            prev_char <= inbound_data;
        end
    end

    // The character pair "of", "to" or "on" picks the operation.
    always_ff @(posedge clk) begin
        if (inbound_valid) begin
            case ({prev_char, inbound_data})
                {O_CHAR, F_CHAR}: instr.op <= OP_OFF;
                {T_CHAR, O_CHAR}: instr.op <= OP_TOGGLE;
                {O_CHAR, N_CHAR}: instr.op <= OP_ON;
                default: begin
                end
            endcase
        end
    end

    // Decimal accumulator that restarts on the first digit of a number.
    always_ff @(posedge clk) begin
        if (inbound_valid && cur_digit) begin
            if (prev_digit) begin
                position <= (position * POS_WIDTH'(10)) + digit_value;
            end else begin
                position <= digit_value;
            end
        end
    end

    // Field index 0 is start row, 1 start col, 2 end row and 3 end col.
    always_ff @(posedge clk) begin
        if (reset) begin
            field <= 2'd0;
        end else begin
            case (field)
                2'd0: if (comma_seen) field <= 2'd1;
                2'd1: if (space_seen) field <= 2'd2;
                2'd2: if (comma_seen) field <= 2'd3;
                default: if (instr.valid) field <= 2'd0;
            endcase
        end
    end

    // A field is complete when its delimiter arrives.
    always_ff @(posedge clk) begin
        case (field)
            2'd0: begin
                if (comma_seen) begin
                    instr.start_row <= position;
                end
            end
            2'd1: begin
                if (space_seen) begin
                    instr.start_col <= position;
                end
            end
            2'd2: begin
                if (comma_seen) begin
                    instr.end_row <= position;
                end
            end
            default: begin
                if (lf_seen) begin
                    instr.end_col <= position;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr.valid <= 1'b0;
            end_of_file <= 1'b0;
        end else begin
            instr.valid <= lf_seen;
            end_of_file <= null_seen;
        end
    end

endmodule

`default_nettype wire

/* light_grid.f */
hw/light_grid_pkg.sv
hw/instr_if.sv
hw/line_decoder.sv
hw/grid_updater.sv
hw/light_counter.sv
hw/light_grid_top.sv
testbench/light_grid_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module light_grid_tb -f light_grid.f -o light_grid_sim
./obj_dir/light_grid_sim | tee sim.log
if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* testbench/light_grid_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module light_grid_tb;

    import light_grid_pkg::*;

    logic clk;
    logic reset;
    logic inbound_valid;
    logic [CHAR_WIDTH-1:0] inbound_data;
    logic count_valid;
    logic [COUNT_WIDTH-1:0] light_count;

    // Instructions of the current file and the bytes that spell them.
    logic [OP_WIDTH-1:0] ops[$];
    int row0[$];
    int col0[$];
    int row1[$];
    int col1[$];
    logic [CHAR_WIDTH-1:0] byte_q[$];

    logic [31:0] lcg_state;
    string test_name;
    int expected;
    bit eof_sent;
    bit watch_on;
    int deadline;
    int cycle_count = 0;
    int pulses = 0;
    int value_errors = 0;
    int passed;
    int failed;

    light_grid_top dut (
        .clk(clk),
        .reset(reset),
        .inbound_valid(inbound_valid),
        .inbound_data(inbound_data),
        .count_valid(count_valid),
        .light_count(light_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int limit);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'({9'd0, lcg_state[30:8]}) % limit;
    endfunction

    task automatic add_instr(input logic [OP_WIDTH-1:0] op, input int r0, input int c0,
                             input int r1, input int c1);
        ops.push_back(op);
        row0.push_back(r0);
        col0.push_back(c0);
        row1.push_back(r1);
        col1.push_back(c1);
    endtask

    task automatic add_random_instr();
        int kind;
        int a;
        int b;
        int c;
        int d;
        kind = rand_below(3);
        a = rand_below(GRID_SIZE);
        b = rand_below(GRID_SIZE);
        c = rand_below(GRID_SIZE);
        d = rand_below(GRID_SIZE);
        add_instr((kind == 0) ? OP_OFF : ((kind == 1) ? OP_TOGGLE : OP_ON),
                  (a < b) ? a : b, (c < d) ? c : d, (a < b) ? b : a, (c < d) ? d : c);
    endtask

    task automatic write_line(input int i, input bit pad);
        string verb;
        string text;
        if (ops[i] == OP_ON) verb = "turn on";
        else if (ops[i] == OP_OFF) verb = "turn off";
        else verb = "toggle";
        if (pad) text = $sformatf("%s %02d,%02d through %02d,%02d", verb,
                                  row0[i], col0[i], row1[i], col1[i]);
        else text = $sformatf("%s %0d,%0d through %0d,%0d", verb,
                              row0[i], col0[i], row1[i], col1[i]);
        for (int k = 0; k < text.len(); k++) byte_q.push_back(text.getc(k));
        byte_q.push_back(LF_CHAR);
    endtask

    // Light by light model of the puzzle rules.
    function automatic int expected_count();
        logic [GRID_SIZE-1:0] lights [GRID_SIZE];
        int total;
        total = 0;
        for (int r = 0; r < GRID_SIZE; r++) lights[r] = '0;
        for (int i = 0; i < ops.size(); i++) begin
            for (int r = row0[i]; r <= row1[i]; r++) begin
                for (int c = col0[i]; c <= col1[i]; c++) begin
                    if (ops[i] == OP_ON) lights[r][c] = 1'b1;
                    else if (ops[i] == OP_OFF) lights[r][c] = 1'b0;
                    else lights[r][c] = ~lights[r][c];
                end
            end
        end
        for (int r = 0; r < GRID_SIZE; r++) begin
            for (int c = 0; c < GRID_SIZE; c++) total += int'(lights[r][c]);
        end
        return total;
    endfunction

    task automatic run_test(input string name, input bit pad, input int max_gap);
        int gap;
        int pulses_before;
        int errors_before;
        test_name = name;
        byte_q.delete();
        for (int i = 0; i < ops.size(); i++) write_line(i, pad);
        byte_q.push_back(NULL_CHAR);
        expected = expected_count();
        @(posedge clk);
        #1;
        reset = 1'b1;
        inbound_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        eof_sent = 1'b0;
        pulses_before = pulses;
        errors_before = value_errors;
        // Every byte and gap, the scan of all rows, and some slack.
        deadline = cycle_count + byte_q.size() * (max_gap + 1) + GRID_SIZE + 1 + 64;
        watch_on = 1'b1;
        for (int i = 0; i < byte_q.size(); i++) begin
            gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
                inbound_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            inbound_valid = 1'b1;
            inbound_data = byte_q[i];
            if (byte_q[i] == NULL_CHAR) eof_sent = 1'b1;
        end
        @(posedge clk);
        #1;
        inbound_valid = 1'b0;
        inbound_data = '0;
        while (pulses == pulses_before) @(negedge clk);
        repeat (2 * GRID_SIZE) @(negedge clk);
        watch_on = 1'b0;
        if (pulses - pulses_before != 1)
            $display("Test %s: count_valid pulsed %0d times for one file",
                     name, pulses - pulses_before);
        if (pulses - pulses_before == 1 && value_errors == errors_before) passed++;
        else failed++;
        ops.delete();
        row0.delete();
        col0.delete();
        row1.delete();
        col1.delete();
    endtask

    // Compares each reported count with the model.
    always @(negedge clk) begin
        if (!reset && count_valid) begin
            pulses++;
            if (!eof_sent) begin
                $display("Test %s: count_valid came before the end-of-file byte", test_name);
                value_errors++;
            end
            if (int'(light_count) != expected) begin
                $display("FAIL %s: expected %0d, actual %0d", test_name, expected, light_count);
                value_errors++;
            end else begin
                $display("PASS %s: expected %0d, actual %0d", test_name, expected, light_count);
            end
        end
    end

    initial begin
        while (!(watch_on && cycle_count > deadline)) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Test %s: no count arrived in time, run stopped", test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        inbound_valid = 1'b0;
        inbound_data = '0;
        lcg_state = 32'h2499_0ad3;
        watch_on = 1'b0;
        deadline = 0;
        eof_sent = 1'b0;
        passed = 0;
        failed = 0;
        add_instr(OP_ON, 0, 0, 15, 15);
        run_test("full_on", 1'b0, 0);
        run_test("null_only", 1'b0, 0);
        add_instr(OP_ON, 2, 2, 9, 9);
        add_instr(OP_OFF, 6, 6, 12, 12);
        run_test("on_then_off", 1'b0, 0);
        add_instr(OP_TOGGLE, 3, 4, 10, 12);
        add_instr(OP_TOGGLE, 3, 4, 10, 12);
        run_test("toggle_twice", 1'b0, 0);
        add_instr(OP_TOGGLE, 1, 5, 7, 14);
        run_test("toggle_once", 1'b0, 2);
        repeat (20) add_random_instr();
        run_test("random_back_to_back", 1'b1, 0);
        repeat (20) add_random_instr();
        run_test("random_gaps", 1'b0, 3);
        $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
